/* count_reporter.f */
hw/count_report_pkg.sv
hw/event_counter.sv
hw/bcd_converter.sv
hw/report_framer.sv
hw/uart_tx.sv
hw/count_reporter.sv
test/tb_count_reporter.sv

/* hw/bcd_converter.sv */
`timescale 1ns/1ns

module bcd_converter
    import count_report_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               done,
    input  logic [COUNT_W-1:0] count,
    output logic               digits_valid,
    output bcd_digits_t        digits
);

    localparam int BCD_W = 4 * NUM_DIGITS;
    localparam int SR_W  = BCD_W + COUNT_W;
    localparam int BIT_W = (COUNT_W > 1) ? $clog2(COUNT_W) : 1;
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(COUNT_W - 1);

    conv_state_e      state;
    logic [SR_W-1:0]  sr;       // bcd digits above, binary below
    logic [SR_W-1:0]  sr_adj;
    logic [SR_W-1:0]  sr_next;
    logic [BIT_W-1:0] bit_cnt;
    logic             start;
    logic             last_shift;

    assign start      = (state == CONV_IDLE) && done;
    assign last_shift = (state == CONV_SHIFT) && (bit_cnt == BIT_LAST);

    // add 3 to every nibble of 5 or more, then shift left
    always_comb begin
        sr_adj = sr;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (sr[COUNT_W + 4*i +: 4] >= 4'd5) begin
                sr_adj[COUNT_W + 4*i +: 4] = sr[COUNT_W + 4*i +: 4] + 4'd3;
            end
        end
        sr_next = sr_adj << 1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= CONV_IDLE;
            bit_cnt      <= '0;
            digits_valid <= 1'b0;
        end else begin
            digits_valid <= 1'b0;
            case (state)
                CONV_IDLE: begin
                    if (done) begin
                        state   <= CONV_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                CONV_SHIFT: begin
                    if (bit_cnt == BIT_LAST) begin
                        state        <= CONV_IDLE;
                        digits_valid <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= CONV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sr <= {{BCD_W{1'b0}}, count};
        end else if (state == CONV_SHIFT) begin
            sr <= sr_next;
        end
        if (last_shift) begin
            digits <= sr_next[SR_W-1 -: BCD_W];  // held until the next result
        end
    end

endmodule

/* hw/count_report_pkg.sv */
package count_report_pkg;

    // width of the per-window event count
    localparam int COUNT_W = 16;

    // decimal digits per report, enough for the full 16-bit range
    localparam int NUM_DIGITS = 5;

    // index NUM_DIGITS-1 holds the most significant digit
    typedef logic [NUM_DIGITS-1:0][3:0] bcd_digits_t;

    // binary to bcd converter
    typedef enum logic {
        CONV_IDLE,
        CONV_SHIFT
    } conv_state_e;

    // report framer, one byte in flight at a time
    typedef enum logic [1:0] {
        FRAME_IDLE,
        FRAME_SEND,
        FRAME_WAIT_BUSY
    } frame_state_e;

    // uart transmitter
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

/* hw/count_reporter.sv */
`timescale 1ns/1ns

module count_reporter
    import count_report_pkg::*;
#(
    parameter int WINDOW_CYCLES = 2000,  // keep below 131072 so the count cannot wrap
    parameter int CLKS_PER_BIT  = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic event_in,
    output logic tx_line
);

    logic               done;
    logic [COUNT_W-1:0] count;
    logic               digits_valid;
    bcd_digits_t        digits;
    logic               tx_start;
    logic [7:0]         tx_byte;
    logic               tx_busy;

    event_counter #(
        .WINDOW_CYCLES(WINDOW_CYCLES)
    ) event_counter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .event_in(event_in),
        .done    (done),
        .count   (count)
    );

    bcd_converter bcd_converter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .done        (done),
        .count       (count),
        .digits_valid(digits_valid),
        .digits      (digits)
    );

    // only stage that sees back-pressure, through tx_busy
    report_framer report_framer_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .digits_valid(digits_valid),
        .digits      (digits),
        .tx_busy     (tx_busy),
        .tx_start    (tx_start),
        .tx_byte     (tx_byte)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_tx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_start(tx_start),
        .tx_byte (tx_byte),
        .tx_busy (tx_busy),
        .tx_line (tx_line)
    );

endmodule

/* hw/event_counter.sv */
`timescale 1ns/1ns

module event_counter
    import count_report_pkg::*;
#(
    parameter int WINDOW_CYCLES = 2000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               event_in,
    output logic               done,
    output logic [COUNT_W-1:0] count
);

    localparam int WIN_W = (WINDOW_CYCLES > 1) ? $clog2(WINDOW_CYCLES) : 1;
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(WINDOW_CYCLES - 1);

    logic [1:0]         sync_q;   // two-flop synchronizer
    logic               event_q;  // synchronized level, one cycle late
    logic               edge_det;
    logic [WIN_W-1:0]   win_cnt;
    logic [COUNT_W-1:0] edge_cnt;
    logic               win_end;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q  <= 2'b00;
            event_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], event_in};
            event_q <= sync_q[1];
        end
    end

    assign edge_det = sync_q[1] & ~event_q;  // rising edge only

    assign win_end = (win_cnt == WIN_LAST);

    // window position, 0 in the first cycle after reset release
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_cnt <= '0;
        end else if (win_end) begin
            win_cnt <= '0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    // an edge seen in the last cycle already belongs to the next window
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            edge_cnt <= '0;
        end else if (win_end) begin
            edge_cnt <= COUNT_W'(edge_det);
        end else if (edge_det) begin
            edge_cnt <= edge_cnt + 1'b1;
        end
    end

    assign done  = win_end;
    assign count = edge_cnt;  // valid while done is high

endmodule

/* hw/report_framer.sv */
`timescale 1ns/1ns

module report_framer
    import count_report_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        digits_valid,
    input  bcd_digits_t digits,
    input  logic        tx_busy,
    output logic        tx_start,
    output logic [7:0]  tx_byte
);

    localparam int NUM_BYTES = NUM_DIGITS + 2;  // digits, CR, LF
    localparam int IDX_W     = $clog2(NUM_BYTES);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NUM_BYTES - 1);
    localparam logic [IDX_W-1:0] IDX_CR   = IDX_W'(NUM_DIGITS);
    localparam logic [IDX_W-1:0] IDX_MSD  = IDX_W'(NUM_DIGITS - 1);

    localparam logic [7:0] ASCII_ZERO = 8'h30;
    localparam logic [7:0] ASCII_CR   = 8'h0D;
    localparam logic [7:0] ASCII_LF   = 8'h0A;

    frame_state_e     state;
    logic [IDX_W-1:0] idx;
    bcd_digits_t      digits_q;
    logic             busy_seen;  // transmitter has picked up the byte
    logic [3:0]       cur_digit;

    assign tx_start = (state == FRAME_SEND) && !tx_busy;

    // byte select: digits msd first, then the line terminator
    always_comb begin
        cur_digit = 4'h0;
        tx_byte   = ASCII_LF;
        if (idx < IDX_CR) begin
            cur_digit = digits_q[IDX_MSD - idx];
            tx_byte   = ASCII_ZERO + {4'h0, cur_digit};
        end else if (idx == IDX_CR) begin
            tx_byte = ASCII_CR;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= FRAME_IDLE;
            idx       <= '0;
            busy_seen <= 1'b0;
        end else begin
            case (state)
                FRAME_IDLE: begin
                    if (digits_valid) begin
                        idx   <= '0;
                        state <= FRAME_SEND;
                    end
                end
                FRAME_SEND: begin
                    if (!tx_busy) begin
                        busy_seen <= 1'b0;
                        state     <= FRAME_WAIT_BUSY;
                    end
                end
                FRAME_WAIT_BUSY: begin
                    if (tx_busy) begin
                        busy_seen <= 1'b1;
                    end else if (busy_seen) begin  // byte fully on the line
                        if (idx == IDX_LAST) begin
                            state <= FRAME_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= FRAME_SEND;
                        end
                    end
                end
                default: state <= FRAME_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FRAME_IDLE && digits_valid) begin
            digits_q <= digits;
        end
    end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx
    import count_report_pkg::*;
#(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx_busy,
    output logic       tx_line
);

    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);

    tx_state_e         state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_idx;
    logic [7:0]        shift_q;   // lsb goes out next
    logic              baud_last;
    logic              shift_en;

    assign baud_last = (baud_cnt == BAUD_LAST);
    assign shift_en  = baud_last &&
                       (state == TX_START || (state == TX_DATA && bit_idx != 3'd7));
    assign tx_busy   = (state != TX_IDLE);

    // bit period counter, parked at zero while idle
    always_ff @(posedge clk) begin
        if (!rst_n || state == TX_IDLE || baud_last) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bit_idx <= 3'd0;
            tx_line <= 1'b1;  // line idles high
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_start) begin
                        state   <= TX_START;
                        tx_line <= 1'b0;  // start bit
                    end
                end
                TX_START: begin
                    if (baud_last) begin
                        state   <= TX_DATA;
                        bit_idx <= 3'd0;
                        tx_line <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (baud_last) begin
                        if (bit_idx == 3'd7) begin
                            state   <= TX_STOP;
                            tx_line <= 1'b1;  // stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_line <= shift_q[0];
                        end
                    end
                end
                TX_STOP: if (baud_last) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shift_q <= tx_byte;
        end else if (shift_en) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

/* test/tb_count_reporter.sv */
`timescale 1ns/1ns

module tb_count_reporter
    import count_report_pkg::*;
();

    localparam int WINDOW_CYCLES  = 2000;
    localparam int CLKS_PER_BIT   = 8;
    localparam int NUM_WINDOWS    = 8;
    localparam int GUARD_CYCLES   = 20;   // no pulses this close to a window edge
    localparam int LONG_HIGH      = 100;
    localparam int MAX_RANDOM     = 400;  // 4-cycle pulses must fit inside the guard bands
    localparam int TIMEOUT_CYCLES = (NUM_WINDOWS + 2) * WINDOW_CYCLES;

    logic clk;
    logic rst_n;
    logic event_in;
    logic tx_line;

    int          error_count;
    int          check_count;
    int          frames_seen;
    int          cycle_count;
    int          expected_q[$];   // one count per window, oldest first
    logic [7:0]  frame_bytes[$];
    logic [31:0] rand_state;

    count_reporter #(
        .WINDOW_CYCLES(WINDOW_CYCLES),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) count_reporter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .event_in(event_in),
        .tx_line (tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_cond(input bit ok, input string msg);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("ERROR %0t: %s", $time, msg);
        end
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one full window of stimulus, starting in its slot 0
    task automatic run_window(input int n_short, input bit long_pulse);
        int used;
        used = GUARD_CYCLES;
        idle_cycles(GUARD_CYCLES);
        if (long_pulse) begin
            event_in = 1'b1;
            idle_cycles(LONG_HIGH);
            event_in = 1'b0;
            idle_cycles(2);
            used += LONG_HIGH + 2;
        end
        for (int i = 0; i < n_short; i++) begin
            event_in = 1'b1;
            idle_cycles(2);
            event_in = 1'b0;
            idle_cycles(2);
        end
        used += 4 * n_short;
        idle_cycles(WINDOW_CYCLES - used);
    endtask

    // called when LF arrives, frame_bytes holds the whole frame
    task automatic check_frame();
        int  value;
        int  expected;
        bit  has_exp;
        bit  ok;
        logic [7:0] b;
        value   = 0;
        has_exp = 1'b0;
        frames_seen++;
        if (expected_q.size() == 0) begin
            report_problem($sformatf("frame %0d arrived with no window pending", frames_seen));
        end else begin
            expected = expected_q.pop_front();
            has_exp  = 1'b1;
        end
        ok = (frame_bytes.size() == NUM_DIGITS + 2);
        check_cond(ok, $sformatf("frame %0d has %0d bytes", frames_seen, frame_bytes.size()));
        if (!ok) return;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            b = frame_bytes[i];
            check_cond(b >= 8'h30 && b <= 8'h39,
                       $sformatf("frame %0d byte %0d is 0x%02h, not a digit", frames_seen, i, b));
            value = value * 10 + int'(b - 8'h30);
        end
        check_cond(frame_bytes[NUM_DIGITS] == 8'h0D,
                   $sformatf("frame %0d has no CR before LF", frames_seen));
        if (has_exp) begin
            check_cond(value == expected,
                       $sformatf("frame %0d reads %0d, expected %0d", frames_seen, value, expected));
        end
    endtask

    // line must stay idle until the first report can start
    initial begin : quiet_line_check
        bit quiet;
        quiet = 1'b1;
        wait (rst_n === 1'b1);
        repeat (WINDOW_CYCLES - 1) begin
            @(negedge clk);
            if (tx_line !== 1'b1) quiet = 1'b0;
        end
        check_cond(quiet, "tx_line left idle before the first window ended");
    end

    // 8N1 receiver model, samples on falling clock edges near mid-bit
    initial begin : serial_decoder
        logic [7:0] rx_byte;
        bit         stop_ok;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge tx_line);
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_cond(tx_line === 1'b0, "start bit did not sample low");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx_byte[i] = tx_line;  // lsb first
            end
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            stop_ok = 1'b1;
            for (int i = 0; i < CLKS_PER_BIT; i++) begin
                @(negedge clk);
                if (tx_line !== 1'b1) stop_ok = 1'b0;
            end
            check_cond(stop_ok, $sformatf("stop bit of byte 0x%02h not high for all cycles",
                                          rx_byte));
            frame_bytes.push_back(rx_byte);
            if (rx_byte == 8'h0A) begin
                check_frame();
                frame_bytes.delete();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d frames received",
                     cycle_count, frames_seen, NUM_WINDOWS);
            $display("checks %0d, errors %0d", check_count, error_count + 1);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int n;
        bit long_pulse;
        error_count = 0;
        check_count = 0;
        frames_seen = 0;
        cycle_count = 0;
        rand_state  = 32'h7bc2abad;
        event_in    = 1'b0;
        rst_n       = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int w = 0; w < NUM_WINDOWS; w++) begin
            if (frames_seen != ((w > 0) ? w - 1 : 0)) begin
                report_problem($sformatf("%0d frames received when window %0d started",
                                         frames_seen, w));
            end
            long_pulse = (w == 2);  // a 100-cycle pulse rides along in this window
            if (w == 0) begin
                n = 0;
            end else if (w == 1) begin
                n = 37;
            end else begin
                rand_state = next_random(rand_state);
                n = int'(rand_state % (MAX_RANDOM + 1));
            end
            expected_q.push_back(n + int'(long_pulse));
            run_window(n, long_pulse);
        end
        wait (frames_seen >= NUM_WINDOWS);
        idle_cycles(10);
        if (expected_q.size() != 0) begin
            report_problem($sformatf("%0d windows never produced a frame", expected_q.size()));
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
